/* logic/uart_pkg.sv */
// uart_pkg: byte type, frame constants, even-parity function

package uart_pkg;

    typedef logic [7:0] uart_byte_t;

    localparam int data_bits = 8;           // data bits per frame

    localparam logic start_level = 1'b0;
    localparam logic stop_level  = 1'b1;    // also the idle line level

    // parity bit that makes the total count of ones even
    function automatic logic even_parity(input uart_byte_t b);
        logic p;
        p = ^b;
        return p;
    endfunction

endpackage

/* logic/uart_rx_if.sv */
// uart_rx_if: received byte and status, receiver to holding register
`timescale 1ns/1ps

interface uart_rx_if;
    import uart_pkg::*;

    uart_byte_t data;
    logic       valid;          // one-cycle strobe
    logic       parity_err;
    logic       frame_err;

    modport rx (
        output data, valid, parity_err, frame_err
    );

    modport holding (
        input data, valid, parity_err, frame_err
    );

endinterface

/* logic/uart_tx.sv */
// transmit FSM with baud timer, bit index and even parity
`timescale 1ns/1ps

module uart_tx #(
    parameter int clks_per_baud = 1250
) (
    input  logic                clk,
    input  logic                nRst,
    input  logic                start,
    input  uart_pkg::uart_byte_t data,
    output logic                ready,
    output logic                serial
);
    import uart_pkg::*;

    localparam int cnt_w = $clog2(clks_per_baud);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop,
        st_clean
    } tx_state_t;

    tx_state_t        state, next_state;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    logic             baud_done;
    logic             last_bit;
    logic             parity_bit;
    uart_byte_t       data_q;

    assign baud_done  = (baud_cnt == cnt_w'(clks_per_baud - 1));
    assign last_bit   = (bit_idx == 3'(data_bits - 1));
    assign parity_bit = even_parity(data_q);
    assign ready      = (state == st_idle);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= st_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            state <= next_state;
            if (state == st_idle || state == st_clean || baud_done) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            if (state == st_idle) begin
                bit_idx <= '0;
            end else if (state == st_data && baud_done) begin
                bit_idx <= bit_idx + 1'b1;   // wraps to 0 after the last bit
            end
        end
    end

    // byte copy, so the host may change data mid-frame
    always_ff @(posedge clk) begin
        if (start && ready) begin
            data_q <= data;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:   if (start) next_state = st_start;
            st_start:  if (baud_done) next_state = st_data;
            st_data:   if (baud_done && last_bit) next_state = st_parity;
            st_parity: if (baud_done) next_state = st_stop;
            st_stop:   if (baud_done) next_state = st_clean;   // full stop period
            st_clean:  next_state = st_idle;
            default:   next_state = st_idle;
        endcase
    end

    always_comb begin
        case (state)
            st_start:  serial = start_level;
            st_data:   serial = data_q[bit_idx];   // lsb first
            st_parity: serial = parity_bit;
            default:   serial = stop_level;
        endcase
    end

    // line stays idle-high whenever a new byte can be accepted
    a_idle_high: assert property (@(posedge clk) disable iff (!nRst)
        ready |-> serial);

    // a strobe during a frame must not restart it
    a_busy_ignored: assert property (@(posedge clk) disable iff (!nRst)
        (start && !ready) |=> (state != st_start || $past(state) == st_start));

endmodule

/* logic/uart_rx.sv */
// uart_rx: line synchronizer, mid-bit sampler, receive FSM, parity and stop checks
`timescale 1ns/1ps

module uart_rx #(
    parameter int clks_per_baud = 1250
) (
    input  logic  clk,
    input  logic  nRst,
    input  logic  serial,
    uart_rx_if.rx rx
);
    import uart_pkg::*;

    localparam int cnt_w     = $clog2(clks_per_baud);
    localparam int half_baud = clks_per_baud / 2;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop
    } rx_state_t;

    rx_state_t        state, next_state;
    logic [1:0]       sync_q;
    logic             line;
    logic             line_q;
    logic             fall;
    logic [cnt_w-1:0] baud_cnt;
    logic             half_done;
    logic             full_done;
    logic             bit_end;
    logic [2:0]       bit_idx;
    logic             valid_q;
    uart_byte_t       shift_q;
    logic             par_err_q;
    logic             frame_err_q;

    assign line      = sync_q[1];
    assign fall      = line_q & ~line;
    assign half_done = (baud_cnt == cnt_w'(half_baud - 1));
    assign full_done = (baud_cnt == cnt_w'(clks_per_baud - 1));
    assign bit_end   = (state == st_start) ? half_done : full_done;   // mid-bit sample point

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= st_idle;
            sync_q   <= '1;
            line_q   <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
            valid_q  <= 1'b0;
        end else begin
            state  <= next_state;
            sync_q <= {sync_q[0], serial};
            line_q <= line;
            if (state == st_idle || bit_end) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            if (state == st_idle) begin
                bit_idx <= '0;
            end else if (state == st_data && bit_end) begin
                bit_idx <= bit_idx + 1'b1;
            end
            valid_q <= (state == st_stop) && bit_end;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && bit_end) begin
            shift_q <= {line, shift_q[data_bits-1:1]};   // lsb arrives first
        end
        if (state == st_parity && bit_end) begin
            par_err_q <= line ^ even_parity(shift_q);
        end
        if (state == st_stop && bit_end) begin
            frame_err_q <= (line != stop_level);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (fall) next_state = st_start;
            end
            st_start: begin
                if (bit_end) begin
                    // glitch if the line is already back high
                    next_state = (line == start_level) ? st_data : st_idle;
                end
            end
            st_data: begin
                if (bit_end && bit_idx == 3'(data_bits - 1)) next_state = st_parity;
            end
            st_parity: begin
                if (bit_end) next_state = st_stop;
            end
            st_stop: begin
                if (bit_end) next_state = st_idle;   // rest of the stop bit is skipped
            end
            default: next_state = st_idle;
        endcase
    end

    assign rx.data       = shift_q;
    assign rx.valid      = valid_q;
    assign rx.parity_err = par_err_q;
    assign rx.frame_err  = frame_err_q;

    a_valid_single: assert property (@(posedge clk) disable iff (!nRst)
        valid_q |=> !valid_q);

endmodule

/* logic/uart_rx_holding.sv */
// uart_rx_holding: host holding register with full, error and overrun flags
`timescale 1ns/1ps

module uart_rx_holding (
    input  logic                 clk,
    input  logic                 nRst,
    uart_rx_if.holding           rx,
    input  logic                 read,
    output uart_pkg::uart_byte_t data,
    output logic                 full,
    output logic                 parity_err,
    output logic                 frame_err,
    output logic                 overrun
);

    always_ff @(posedge clk) begin
        if (rx.valid) begin
            data <= rx.data;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            full       <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            if (rx.valid) begin
                parity_err <= rx.parity_err;
                frame_err  <= rx.frame_err;
            end

            if (rx.valid) begin
                full <= 1'b1;   // a new byte wins over a read
            end else if (read) begin
                full <= 1'b0;
            end

            // unread byte replaced
            if (rx.valid && full && !read) begin
                overrun <= 1'b1;
            end else if (read) begin
                overrun <= 1'b0;
            end
        end
    end

    a_overrun_full: assert property (@(posedge clk) disable iff (!nRst)
        overrun |-> full);

endmodule

/* logic/uart_top.sv */
// uart_top: transmitter, receiver and holding register with plain ports
`timescale 1ns/1ps

module uart_top #(
    parameter int clks_per_baud = 1250
) (
    input  logic       clk,
    input  logic       nRst,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx_ready,
    output logic       tx_serial,
    input  logic       rx_serial,
    input  logic       rx_read,
    output logic [7:0] rx_data,
    output logic       rx_full,
    output logic       rx_parity_err,
    output logic       rx_frame_err,
    output logic       rx_overrun
);

    uart_rx_if rx_bus ();

    uart_tx #(
        .clks_per_baud(clks_per_baud)
    ) i_tx (
        .clk    (clk),
        .nRst   (nRst),
        .start  (tx_start),
        .data   (tx_data),
        .ready  (tx_ready),
        .serial (tx_serial)
    );

    uart_rx #(
        .clks_per_baud(clks_per_baud)
    ) i_rx (
        .clk    (clk),
        .nRst   (nRst),
        .serial (rx_serial),
        .rx     (rx_bus.rx)
    );

    uart_rx_holding i_holding (
        .clk        (clk),
        .nRst       (nRst),
        .rx         (rx_bus.holding),
        .read       (rx_read),
        .data       (rx_data),
        .full       (rx_full),
        .parity_err (rx_parity_err),
        .frame_err  (rx_frame_err),
        .overrun    (rx_overrun)
    );

endmodule

/* verif/uart_tb.sv */
// uart_tb: loopback and error-injection testbench for uart_top, reference frame model and checker
`timescale 1ns/1ps

module uart_tb;
    localparam int clks_per_baud = 8;
    localparam int frame_bits    = 11;
    localparam int wait_limit    = 4 * 12 * clks_per_baud;
    localparam int watchdog_ns   = 40 * 12 * clks_per_baud * 40 + 20000;

    logic        clk, nRst, tx_start, tx_ready, tx_serial, rx_serial, rx_read;
    logic [7:0]  tx_data, rx_data;
    logic        rx_full, rx_parity_err, rx_frame_err, rx_overrun;
    logic        use_tb_line, tb_line, ready_q;
    logic [31:0] seed;
    logic [7:0]  tx_expect[$];   // bytes the line monitor has yet to see
    int          errors = 0;
    int          checks = 0;

    assign rx_serial = use_tb_line ? tb_line : tx_serial;   // loopback unless injecting

    uart_top #(.clks_per_baud(clks_per_baud)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // start, data lsb first, even parity from a ones count, stop
    function automatic logic [10:0] make_frame(input logic [7:0] b);
        logic [10:0] f;
        int          ones;
        int          i;
        ones = 0;
        f[0] = 1'b0;
        for (i = 0; i < 8; i++) begin
            f[i+1] = b[i];
            ones = ones + int'(b[i]);
        end
        f[9]  = ones[0];
        f[10] = 1'b1;
        return f;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // 0 tx_ready, 1 rx_full, 2 rx_overrun
    task automatic wait_until_set(input int sel, input string what);
        int   n;
        logic flag;
        n = 0;
        flag = 1'b0;
        while (!flag && n < wait_limit) begin
            @(negedge clk);
            case (sel)
                0:       flag = (tx_ready === 1'b1);
                1:       flag = (rx_full === 1'b1);
                default: flag = (rx_overrun === 1'b1);
            endcase
            n++;
        end
        if (!flag) begin
            errors++;
            $display("timed out waiting for %s to go high", what);
        end
    endtask

    task automatic transmit_byte(input logic [7:0] b, input logic busy_strobe);
        @(negedge clk);
        tx_data = b;
        tx_start = 1'b1;
        tx_expect.push_back(b);
        @(negedge clk);
        tx_start = 1'b0;
        if (busy_strobe) begin
            repeat (3 * clks_per_baud) @(negedge clk);
            tx_data = ~b;       // must be ignored mid-frame
            tx_start = 1'b1;
            @(negedge clk);
            tx_start = 1'b0;
        end
        wait_until_set(0, "tx_ready");
    endtask

    task automatic drive_frame(input logic [7:0] b, input logic flip_parity, input logic low_stop);
        logic [10:0] f;
        int          k;
        f = make_frame(b);
        if (flip_parity) f[9] = ~f[9];
        if (low_stop) f[10] = 1'b0;
        @(negedge clk);
        for (k = 0; k < frame_bits; k++) begin
            tb_line = f[k];
            repeat (clks_per_baud) @(negedge clk);
        end
        tb_line = 1'b1;
    endtask

    task automatic read_rx();
        @(negedge clk);
        rx_read = 1'b1;
        @(negedge clk);
        rx_read = 1'b0;
        check("rx_full", 32'(rx_full), 32'd0);
        check("rx_overrun", 32'(rx_overrun), 32'd0);
    endtask

    task automatic check_rx(input logic [7:0] b, input logic perr, input logic ferr);
        check("rx_data", 32'(rx_data), 32'(b));
        check("rx_full", 32'(rx_full), 32'd1);
        check("rx_parity_err", 32'(rx_parity_err), 32'(perr));
        check("rx_frame_err", 32'(rx_frame_err), 32'(ferr));
    endtask

    // samples tx_serial at each mid-bit once tx_ready drops
    initial begin : tx_monitor
        logic [10:0] exp_frame;
        int          k;
        int          n;
        ready_q = 1'b0;
        forever begin
            @(negedge clk);
            if (nRst === 1'b1 && ready_q === 1'b1 && tx_ready === 1'b0) begin
                exp_frame = '1;
                if (tx_expect.size() == 0) begin
                    errors++;
                    $display("transmitter started a frame that was never requested");
                end else begin
                    exp_frame = make_frame(tx_expect.pop_front());
                end
                for (k = 0; k < frame_bits; k++) begin
                    repeat ((k == 0) ? clks_per_baud / 2 : clks_per_baud) @(negedge clk);
                    check($sformatf("tx_serial bit %0d", k), 32'(tx_serial), 32'(exp_frame[k]));
                end
                n = clks_per_baud / 2 + (frame_bits - 1) * clks_per_baud;
                while (tx_ready !== 1'b1 && n < wait_limit) begin
                    @(negedge clk);
                    n++;
                end
                check("tx_ready delay", 32'(n), 32'(frame_bits * clks_per_baud + 1));
            end
            ready_q = tx_ready;
        end
    end

    initial begin : stimulus
        logic [7:0] b, b2;
        int         i;
        nRst = 1'b0;
        tx_start = 1'b0;
        tx_data = 8'h00;
        rx_read = 1'b0;
        use_tb_line = 1'b0;
        tb_line = 1'b1;
        seed = 32'hc02c;
        repeat (2) @(negedge clk);
        nRst = 1'b1;
        @(negedge clk);
        check("tx_serial", 32'(tx_serial), 32'd1);
        check("tx_ready", 32'(tx_ready), 32'd1);
        check("rx_full", 32'(rx_full), 32'd0);
        check("rx_parity_err", 32'(rx_parity_err), 32'd0);
        check("rx_frame_err", 32'(rx_frame_err), 32'd0);
        check("rx_overrun", 32'(rx_overrun), 32'd0);

        for (i = 0; i < 20; i++) begin
            seed = lcg_next(seed);
            b = seed[23:16];
            transmit_byte(b, 1'b1);
            wait_until_set(1, "rx_full");
            check_rx(b, 1'b0, 1'b0);
            read_rx();
        end

        use_tb_line = 1'b1;
        seed = lcg_next(seed);
        b = seed[23:16];
        drive_frame(b, 1'b1, 1'b0);
        wait_until_set(1, "rx_full");
        check_rx(b, 1'b1, 1'b0);
        read_rx();
        repeat (clks_per_baud) @(negedge clk);
        seed = lcg_next(seed);
        b = seed[23:16];
        drive_frame(b, 1'b0, 1'b1);
        wait_until_set(1, "rx_full");
        check_rx(b, 1'b0, 1'b1);
        read_rx();
        repeat (clks_per_baud) @(negedge clk);
        use_tb_line = 1'b0;

        seed = lcg_next(seed);
        b = seed[23:16];
        seed = lcg_next(seed);
        b2 = (seed[23:16] == b) ? ~b : seed[23:16];
        transmit_byte(b, 1'b0);
        wait_until_set(1, "rx_full");
        check("rx_overrun", 32'(rx_overrun), 32'd0);
        transmit_byte(b2, 1'b0);
        wait_until_set(2, "rx_overrun");
        check_rx(b2, 1'b0, 1'b0);
        read_rx();

        check("tx frames outstanding", tx_expect.size(), 32'd0);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* uart_top.f */
logic/uart_pkg.sv
logic/uart_rx_if.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_rx_holding.sv
logic/uart_top.sv
verif/uart_tb.sv

/* Makefile */
# Verilator build and run for the UART testbench

TOP := uart_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): uart_top.f $(wildcard logic/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -f uart_top.f --top-module $(TOP) -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
